// File: common/fir_pkg.sv
package fir_pkg;

	// axi4-lite bus geometry
	localparam int AXI_DATA_W = 32;
	localparam int AXI_ADDR_W = 16;
	// byte address to word address
	localparam int ADDR_LSB = 2;
	localparam int WORD_ADDR_W = AXI_ADDR_W - ADDR_LSB;

	// word address split into block field and tap index
	localparam int BRAM_ADDR_W = 7;
	localparam int DSP_ADDR_W = WORD_ADDR_W - BRAM_ADDR_W;

	// filter geometry
	localparam int TM = 8;
	localparam int DSP_NR = 2;
	localparam int NTAPS = TM * DSP_NR;
	localparam int COUNT_W = $clog2(TM);

	// datapath widths
	localparam int DATA_W = 14;
	localparam int COEF_W = 18;
	localparam int COEF_MAG = 17;
	// enough for bits COEF_MAG+DATA_W-1..COEF_MAG of the wrapped sum
	localparam int SUM_W = DATA_W + COEF_MAG;
	localparam int PROD_W = DATA_W + COEF_W;

	// coefficient blocks start here, stage s at FIR_COEFS_BASE + s
	localparam int FIR_COEFS_BASE = 1;

	// switch register bits
	localparam int SW_FIR_EN = 1;
	localparam int LED_W = 7;

	// identification words, ascii, read back byte reversed
	localparam logic [AXI_DATA_W-1:0] PROG_NAME = " RIF";
	localparam logic [AXI_DATA_W-1:0] PROG_VER = "12.1";

	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

	// register word addresses
	typedef enum logic [WORD_ADDR_W-1:0] {
		REG_NAME      = 14'd0,
		REG_VER       = 14'd1,
		REG_NTAPS     = 14'd4,
		REG_TM        = 14'd8,
		REG_DSP_NR    = 14'd9,
		REG_COEF_MAG  = 14'd12,
		REG_COEF_BASE = 14'd16,
		REG_SWITCHES  = 14'd20
	} reg_addr_e;

endpackage

// File: common/coef_wr_if.sv
interface coef_wr_if;

	// one-cycle write strobe, no back-pressure
	logic en;
	// stage number, already offset by the block base
	logic [fir_pkg::DSP_ADDR_W-1:0] stage;
	// tap index inside the stage
	logic [fir_pkg::BRAM_ADDR_W-1:0] tap;
	// signed coefficient value
	logic signed [fir_pkg::COEF_W-1:0] data;

	// register slave side
	modport regs (
		output en,
		output stage,
		output tap,
		output data
	);

	// filter side, fanned out to the stages
	modport engine (
		input en,
		input stage,
		input tap,
		input data
	);

endinterface

// File: rtl/axi_lite_regs.sv
module axi_lite_regs (
	input  logic                                 S_AXI_ACLK,
	input  logic                                 S_AXI_ARESETN,
	input  logic [fir_pkg::AXI_ADDR_W-1:0]       S_AXI_AWADDR,
	input  logic                                 S_AXI_AWVALID,
	output logic                                 S_AXI_AWREADY,
	input  logic [fir_pkg::AXI_DATA_W-1:0]       S_AXI_WDATA,
	input  logic [fir_pkg::AXI_DATA_W/8-1:0]     S_AXI_WSTRB,
	input  logic                                 S_AXI_WVALID,
	output logic                                 S_AXI_WREADY,
	output logic [1:0]                           S_AXI_BRESP,
	output logic                                 S_AXI_BVALID,
	input  logic                                 S_AXI_BREADY,
	input  logic [fir_pkg::AXI_ADDR_W-1:0]       S_AXI_ARADDR,
	input  logic                                 S_AXI_ARVALID,
	output logic                                 S_AXI_ARREADY,
	output logic [fir_pkg::AXI_DATA_W-1:0]       S_AXI_RDATA,
	output logic [1:0]                           S_AXI_RRESP,
	output logic                                 S_AXI_RVALID,
	input  logic                                 S_AXI_RREADY,
	output logic [fir_pkg::LED_W-1:0]            leds,
	output logic                                 fir_en,
	coef_wr_if.regs                              coef_wr
);

	// latched word addresses
	logic [fir_pkg::WORD_ADDR_W-1:0] awaddr;
	logic [fir_pkg::WORD_ADDR_W-1:0] araddr;
	// low while a write response is outstanding
	logic aw_en;
	logic aw_accept;
	logic reg_wren;
	logic ar_accept;
	logic [fir_pkg::AXI_DATA_W-1:0] rd_data;
	logic [fir_pkg::AXI_DATA_W-1:0] switches;
	// coefficient address fields
	logic [fir_pkg::DSP_ADDR_W-1:0] blk;
	logic [fir_pkg::BRAM_ADDR_W-1:0] tap_idx;
	logic coef_hit;

	assign S_AXI_BRESP = fir_pkg::AXI_RESP_OKAY;
	assign S_AXI_RRESP = fir_pkg::AXI_RESP_OKAY;

	// both channels must be valid, and no response pending
	assign aw_accept = !S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WVALID && aw_en;
	assign reg_wren = S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WREADY && S_AXI_WVALID;

	// awready and wready pulse together
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			S_AXI_AWREADY <= 1'b0;
			S_AXI_WREADY <= 1'b0;
			aw_en <= 1'b1;
		end else if (aw_accept) begin
			S_AXI_AWREADY <= 1'b1;
			S_AXI_WREADY <= 1'b1;
			aw_en <= 1'b0;
		end else begin
			S_AXI_AWREADY <= 1'b0;
			S_AXI_WREADY <= 1'b0;
			// response taken, next write may start
			if (S_AXI_BVALID && S_AXI_BREADY)
				aw_en <= 1'b1;
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (aw_accept)
			awaddr <= S_AXI_AWADDR[fir_pkg::AXI_ADDR_W-1:fir_pkg::ADDR_LSB];
	end

	// write response, held until bready
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			S_AXI_BVALID <= 1'b0;
		else if (reg_wren && !S_AXI_BVALID)
			S_AXI_BVALID <= 1'b1;
		else if (S_AXI_BVALID && S_AXI_BREADY)
			S_AXI_BVALID <= 1'b0;
	end

	// switch register with byte lanes
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			switches <= '0;
		end else if (reg_wren && awaddr == fir_pkg::REG_SWITCHES) begin
			for (int b = 0; b < fir_pkg::AXI_DATA_W / 8; b++) begin
				if (S_AXI_WSTRB[b])
					switches[b*8 +: 8] <= S_AXI_WDATA[b*8 +: 8];
			end
		end
	end

	assign leds = switches[fir_pkg::LED_W-1:0];
	assign fir_en = switches[fir_pkg::SW_FIR_EN];

	// block field picks the stage, low field the tap
	assign blk = awaddr[fir_pkg::WORD_ADDR_W-1:fir_pkg::BRAM_ADDR_W];
	assign tap_idx = awaddr[fir_pkg::BRAM_ADDR_W-1:0];
	assign coef_hit = (blk >= fir_pkg::DSP_ADDR_W'(fir_pkg::FIR_COEFS_BASE)) &&
		(blk < fir_pkg::DSP_ADDR_W'(fir_pkg::FIR_COEFS_BASE + fir_pkg::DSP_NR)) &&
		(tap_idx < fir_pkg::BRAM_ADDR_W'(fir_pkg::TM));

	// strobe one clock after the accepting cycle
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			coef_wr.en <= 1'b0;
		else
			coef_wr.en <= reg_wren && coef_hit;
	end

	// sign from bit 31, magnitude bits from the bottom
	always_ff @(posedge S_AXI_ACLK) begin
		coef_wr.stage <= blk - fir_pkg::DSP_ADDR_W'(fir_pkg::FIR_COEFS_BASE);
		coef_wr.tap <= tap_idx;
		coef_wr.data <= {S_AXI_WDATA[fir_pkg::AXI_DATA_W-1], S_AXI_WDATA[fir_pkg::COEF_W-2:0]};
	end

	// read address, not taken while data waits
	assign ar_accept = !S_AXI_ARREADY && S_AXI_ARVALID && !S_AXI_RVALID;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			S_AXI_ARREADY <= 1'b0;
		else
			S_AXI_ARREADY <= ar_accept;
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (ar_accept)
			araddr <= S_AXI_ARADDR[fir_pkg::AXI_ADDR_W-1:fir_pkg::ADDR_LSB];
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			S_AXI_RVALID <= 1'b0;
		else if (S_AXI_ARREADY && S_AXI_ARVALID && !S_AXI_RVALID)
			S_AXI_RVALID <= 1'b1;
		else if (S_AXI_RVALID && S_AXI_RREADY)
			S_AXI_RVALID <= 1'b0;
	end

	// read decode, coefficients are write only
	always_comb begin
		case (fir_pkg::reg_addr_e'(araddr))
			fir_pkg::REG_NAME:      rd_data = fir_pkg::PROG_NAME;
			fir_pkg::REG_VER:       rd_data = fir_pkg::PROG_VER;
			fir_pkg::REG_NTAPS:     rd_data = fir_pkg::AXI_DATA_W'(fir_pkg::NTAPS);
			fir_pkg::REG_TM:        rd_data = fir_pkg::AXI_DATA_W'(fir_pkg::TM);
			fir_pkg::REG_DSP_NR:    rd_data = fir_pkg::AXI_DATA_W'(fir_pkg::DSP_NR);
			fir_pkg::REG_COEF_MAG:  rd_data = fir_pkg::AXI_DATA_W'(fir_pkg::COEF_MAG);
			fir_pkg::REG_COEF_BASE: rd_data = fir_pkg::AXI_DATA_W'(fir_pkg::FIR_COEFS_BASE);
			fir_pkg::REG_SWITCHES:  rd_data = switches;
			default:                rd_data = '0;
		endcase
	end

	// data captured with the address phase, held while rvalid waits
	always_ff @(posedge S_AXI_ACLK) begin
		if (S_AXI_ARREADY && S_AXI_ARVALID && !S_AXI_RVALID)
			S_AXI_RDATA <= rd_data;
	end

	// a response once raised stays up until the master takes it
	a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID);

	// read data frozen until rready
	a_rdata_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA));

endmodule

// File: fir/fir_tap.sv
module fir_tap (
	input  logic                                S_AXI_ACLK,
	input  logic                                S_AXI_ARESETN,
	input  logic [fir_pkg::COUNT_W-1:0]         count,
	input  logic                                shift,
	input  logic signed [fir_pkg::DATA_W-1:0]   sample_in,
	output logic signed [fir_pkg::DATA_W-1:0]   sample_out,
	output logic signed [fir_pkg::SUM_W-1:0]    sum_out,
	input  logic                                coef_en,
	input  logic [fir_pkg::COUNT_W-1:0]         coef_tap,
	input  logic signed [fir_pkg::COEF_W-1:0]   coef_data
);

	logic signed [fir_pkg::COEF_W-1:0] coef [fir_pkg::TM];
	// hist[0] newest, hist[TM-1] oldest
	logic signed [fir_pkg::DATA_W-1:0] hist [fir_pkg::TM];
	logic signed [fir_pkg::PROD_W-1:0] mult;
	logic signed [fir_pkg::SUM_W-1:0] prod;
	// tap index of the product now in prod
	logic [fir_pkg::COUNT_W-1:0] count_q;
	logic signed [fir_pkg::SUM_W-1:0] acc;

	// coefficient store, cleared at reset
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			for (int i = 0; i < fir_pkg::TM; i++)
				coef[i] <= '0;
		end else if (coef_en) begin
			coef[coef_tap] <= coef_data;
		end
	end

	// sample history, one push per frame
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			for (int i = 0; i < fir_pkg::TM; i++)
				hist[i] <= '0;
		end else if (shift) begin
			hist[0] <= sample_in;
			for (int i = 1; i < fir_pkg::TM; i++)
				hist[i] <= hist[i-1];
		end
	end

	// oldest sample moves on to the next stage
	assign sample_out = hist[fir_pkg::TM-1];

	// one tap per clock, same index for coefficient and sample
	assign mult = coef[count] * hist[count];

	// products arrive in order 1..TM-1 then 0
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			prod <= '0;
			count_q <= '0;
			acc <= '0;
			sum_out <= '0;
		end else begin
			// wraps, only low SUM_W bits matter after scaling
			prod <= mult[fir_pkg::SUM_W-1:0];
			count_q <= count;
			if (count_q == fir_pkg::COUNT_W'(1))
				acc <= prod;
			else
				acc <= acc + prod;
			// last product closes the frame sum
			if (count_q == '0)
				sum_out <= acc + prod;
		end
	end

endmodule

// File: fir/fir_engine.sv
module fir_engine (
	input  logic                                S_AXI_ACLK,
	input  logic                                S_AXI_ARESETN,
	input  logic signed [fir_pkg::DATA_W-1:0]   flt_in,
	input  logic                                fir_en,
	output logic signed [fir_pkg::DATA_W-1:0]   flt_out,
	output logic                                flt_tick,
	coef_wr_if.engine                           coef_wr
);

	// position inside the frame
	logic [fir_pkg::COUNT_W-1:0] count;
	logic shift;
	// sample chain, element s feeds stage s
	logic signed [fir_pkg::DATA_W-1:0] sample_chain [fir_pkg::DSP_NR+1];
	logic signed [fir_pkg::SUM_W-1:0] stage_sum [fir_pkg::DSP_NR];
	logic stage_wr_en [fir_pkg::DSP_NR];
	logic signed [fir_pkg::SUM_W-1:0] total;
	// scaled output, one per frame
	logic signed [fir_pkg::DATA_W-1:0] y_q;

	// free running frame counter
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			count <= '0;
		else if (count == fir_pkg::COUNT_W'(fir_pkg::TM - 1))
			count <= '0;
		else
			count <= count + 1'b1;
	end

	// frame strobe, input captured at its closing edge
	assign flt_tick = (count == '0);
	assign shift = flt_tick;

	assign sample_chain[0] = flt_in;

	for (genvar s = 0; s < fir_pkg::DSP_NR; s++) begin : g_stage
		// strobe only the addressed stage
		assign stage_wr_en[s] = coef_wr.en && (coef_wr.stage == fir_pkg::DSP_ADDR_W'(s));

		fir_tap u_tap (
			.S_AXI_ACLK    (S_AXI_ACLK),
			.S_AXI_ARESETN (S_AXI_ARESETN),
			.count         (count),
			.shift         (shift),
			.sample_in     (sample_chain[s]),
			.sample_out    (sample_chain[s+1]),
			.sum_out       (stage_sum[s]),
			.coef_en       (stage_wr_en[s]),
			.coef_tap      (coef_wr.tap[fir_pkg::COUNT_W-1:0]),
			.coef_data     (coef_wr.data)
		);
	end

	// add the stage sums, wrapping
	always_comb begin
		total = '0;
		for (int s = 0; s < fir_pkg::DSP_NR; s++)
			total = total + stage_sum[s];
	end

	// stage sums are steady at count 0, so take y there
	// holds through the whole next frame
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			y_q <= '0;
		else if (count == '0)
			y_q <= total[fir_pkg::COEF_MAG +: fir_pkg::DATA_W];
	end

	// bypass when the filter is off
	assign flt_out = fir_en ? y_q : flt_in;

	// tap index is cut to COUNT_W bits at the stages
	// a strobe must point at a real stage and tap
	a_coef_wr_range: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		coef_wr.en |-> coef_wr.tap < fir_pkg::BRAM_ADDR_W'(fir_pkg::TM) &&
		coef_wr.stage < fir_pkg::DSP_ADDR_W'(fir_pkg::DSP_NR));

endmodule

// File: rtl/fir_axi_top.sv
module fir_axi_top (
	input  logic                                S_AXI_ACLK,
	input  logic                                S_AXI_ARESETN,
	input  logic [fir_pkg::AXI_ADDR_W-1:0]      S_AXI_AWADDR,
	input  logic                                S_AXI_AWVALID,
	output logic                                S_AXI_AWREADY,
	input  logic [fir_pkg::AXI_DATA_W-1:0]      S_AXI_WDATA,
	input  logic [fir_pkg::AXI_DATA_W/8-1:0]    S_AXI_WSTRB,
	input  logic                                S_AXI_WVALID,
	output logic                                S_AXI_WREADY,
	output logic [1:0]                          S_AXI_BRESP,
	output logic                                S_AXI_BVALID,
	input  logic                                S_AXI_BREADY,
	input  logic [fir_pkg::AXI_ADDR_W-1:0]      S_AXI_ARADDR,
	input  logic                                S_AXI_ARVALID,
	output logic                                S_AXI_ARREADY,
	output logic [fir_pkg::AXI_DATA_W-1:0]      S_AXI_RDATA,
	output logic [1:0]                          S_AXI_RRESP,
	output logic                                S_AXI_RVALID,
	input  logic                                S_AXI_RREADY,
	input  logic signed [fir_pkg::DATA_W-1:0]   flt_in,
	output logic signed [fir_pkg::DATA_W-1:0]   flt_out,
	output logic                                flt_tick,
	output logic [fir_pkg::LED_W-1:0]           leds
);

	// filter on/off from the switch register
	logic fir_en;

	// coefficient writes, slave to filter
	coef_wr_if coef_wr ();

	axi_lite_regs u_regs (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.S_AXI_AWADDR  (S_AXI_AWADDR),
		.S_AXI_AWVALID (S_AXI_AWVALID),
		.S_AXI_AWREADY (S_AXI_AWREADY),
		.S_AXI_WDATA   (S_AXI_WDATA),
		.S_AXI_WSTRB   (S_AXI_WSTRB),
		.S_AXI_WVALID  (S_AXI_WVALID),
		.S_AXI_WREADY  (S_AXI_WREADY),
		.S_AXI_BRESP   (S_AXI_BRESP),
		.S_AXI_BVALID  (S_AXI_BVALID),
		.S_AXI_BREADY  (S_AXI_BREADY),
		.S_AXI_ARADDR  (S_AXI_ARADDR),
		.S_AXI_ARVALID (S_AXI_ARVALID),
		.S_AXI_ARREADY (S_AXI_ARREADY),
		.S_AXI_RDATA   (S_AXI_RDATA),
		.S_AXI_RRESP   (S_AXI_RRESP),
		.S_AXI_RVALID  (S_AXI_RVALID),
		.S_AXI_RREADY  (S_AXI_RREADY),
		.leds          (leds),
		.fir_en        (fir_en),
		.coef_wr       (coef_wr.regs)
	);

	fir_engine u_engine (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.flt_in        (flt_in),
		.fir_en        (fir_en),
		.flt_out       (flt_out),
		.flt_tick      (flt_tick),
		.coef_wr       (coef_wr.engine)
	);

endmodule

// File: tests/fir_axi_tb.sv
module fir_axi_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// clocks allowed for any single handshake or tick wait
	localparam int WAIT_LIMIT = 64;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	logic [fir_pkg::AXI_ADDR_W-1:0] S_AXI_AWADDR;
	logic S_AXI_AWVALID;
	logic S_AXI_AWREADY;
	logic [fir_pkg::AXI_DATA_W-1:0] S_AXI_WDATA;
	logic [fir_pkg::AXI_DATA_W/8-1:0] S_AXI_WSTRB;
	logic S_AXI_WVALID;
	logic S_AXI_WREADY;
	logic [1:0] S_AXI_BRESP;
	logic S_AXI_BVALID;
	logic S_AXI_BREADY;
	logic [fir_pkg::AXI_ADDR_W-1:0] S_AXI_ARADDR;
	logic S_AXI_ARVALID;
	logic S_AXI_ARREADY;
	logic [fir_pkg::AXI_DATA_W-1:0] S_AXI_RDATA;
	logic [1:0] S_AXI_RRESP;
	logic S_AXI_RVALID;
	logic S_AXI_RREADY;
	logic signed [fir_pkg::DATA_W-1:0] flt_in;
	logic signed [fir_pkg::DATA_W-1:0] flt_out;
	logic flt_tick;
	logic [fir_pkg::LED_W-1:0] leds;

	// reference model state, index k pairs c[k] with x[n-k]
	int coef_m [fir_pkg::NTAPS];
	int hist_m [fir_pkg::NTAPS];
	// outputs still in the filter pipeline
	logic signed [fir_pkg::DATA_W-1:0] exp_q [$];

	fir_axi_top UUT (.*);

	initial begin
		S_AXI_ACLK = 1'b0;
		forever #20 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] want);
		assert (got === want) else
			abort_run($sformatf("ERROR: %s = 0x%h, expected 0x%h", name, got, want));
	endtask

	function automatic logic [fir_pkg::AXI_ADDR_W-1:0] reg_addr(input fir_pkg::reg_addr_e r);
		return fir_pkg::AXI_ADDR_W'(r) << fir_pkg::ADDR_LSB;
	endfunction

	// block field above the tap index, stage 0 at the coefficient base
	function automatic logic [fir_pkg::AXI_ADDR_W-1:0] coef_addr(input int stage, input int tap);
		return fir_pkg::AXI_ADDR_W'(((fir_pkg::FIR_COEFS_BASE + stage) * (2 ** fir_pkg::BRAM_ADDR_W)
			+ tap) * (2 ** fir_pkg::ADDR_LSB));
	endfunction

	// y[n] = sum c[k]*x[n-k], shifted right, low bits kept
	function automatic logic signed [fir_pkg::DATA_W-1:0] expected_output();
		longint acc;
		acc = 0;
		for (int k = 0; k < fir_pkg::NTAPS; k++)
			acc += longint'(coef_m[k]) * longint'(hist_m[k]);
		return fir_pkg::DATA_W'(acc >>> fir_pkg::COEF_MAG);
	endfunction

	task automatic axi_write(input logic [fir_pkg::AXI_ADDR_W-1:0] addr, input logic [31:0] data);
		int cycles;
		cycles = 0;
		@(negedge S_AXI_ACLK);
		S_AXI_AWADDR = addr;
		S_AXI_WDATA = data;
		S_AXI_WSTRB = '1;
		S_AXI_AWVALID = 1'b1;
		S_AXI_WVALID = 1'b1;
		S_AXI_BREADY = 1'b1;
		while (!S_AXI_AWREADY) begin
			@(negedge S_AXI_ACLK);
			cycles++;
			if (cycles > WAIT_LIMIT)
				abort_run("timeout waiting for awready on a write");
		end
		check_eq("S_AXI_WREADY", S_AXI_WREADY, 1);
		// handshake at the next rising edge
		@(negedge S_AXI_ACLK);
		S_AXI_AWVALID = 1'b0;
		S_AXI_WVALID = 1'b0;
		cycles = 0;
		while (!S_AXI_BVALID) begin
			@(negedge S_AXI_ACLK);
			cycles++;
			if (cycles > WAIT_LIMIT)
				abort_run("timeout waiting for bvalid on a write");
		end
		check_eq("S_AXI_BRESP", S_AXI_BRESP, fir_pkg::AXI_RESP_OKAY);
		@(negedge S_AXI_ACLK);
		S_AXI_BREADY = 1'b0;
	endtask

	task automatic axi_read(input logic [fir_pkg::AXI_ADDR_W-1:0] addr, output logic [31:0] data);
		int cycles;
		cycles = 0;
		@(negedge S_AXI_ACLK);
		S_AXI_ARADDR = addr;
		S_AXI_ARVALID = 1'b1;
		S_AXI_RREADY = 1'b1;
		while (!S_AXI_ARREADY) begin
			@(negedge S_AXI_ACLK);
			cycles++;
			if (cycles > WAIT_LIMIT)
				abort_run("timeout waiting for arready on a read");
		end
		@(negedge S_AXI_ACLK);
		S_AXI_ARVALID = 1'b0;
		cycles = 0;
		while (!S_AXI_RVALID) begin
			@(negedge S_AXI_ACLK);
			cycles++;
			if (cycles > WAIT_LIMIT)
				abort_run("timeout waiting for rvalid on a read");
		end
		data = S_AXI_RDATA;
		check_eq("S_AXI_RRESP", S_AXI_RRESP, fir_pkg::AXI_RESP_OKAY);
		@(negedge S_AXI_ACLK);
		S_AXI_RREADY = 1'b0;
	endtask

	// bready low for a while with the write still offered
	// only one accept may happen over the whole exchange
	task automatic write_stalled_response(input logic [fir_pkg::AXI_ADDR_W-1:0] addr,
		input logic [31:0] data, input int stall);
		int cycles;
		int accepts;
		cycles = 0;
		@(negedge S_AXI_ACLK);
		S_AXI_AWADDR = addr;
		S_AXI_WDATA = data;
		S_AXI_WSTRB = '1;
		S_AXI_AWVALID = 1'b1;
		S_AXI_WVALID = 1'b1;
		S_AXI_BREADY = 1'b0;
		while (!S_AXI_AWREADY) begin
			@(negedge S_AXI_ACLK);
			cycles++;
			if (cycles > WAIT_LIMIT)
				abort_run("timeout waiting for awready on a stalled write");
		end
		check_eq("S_AXI_WREADY", S_AXI_WREADY, 1);
		accepts = 1;
		@(negedge S_AXI_ACLK);
		// valids stay up while the response waits
		repeat (stall) begin
			check_eq("S_AXI_BVALID", S_AXI_BVALID, 1);
			@(negedge S_AXI_ACLK);
			if (S_AXI_AWREADY)
				accepts++;
		end
		check_eq("S_AXI_BVALID", S_AXI_BVALID, 1);
		S_AXI_AWVALID = 1'b0;
		S_AXI_WVALID = 1'b0;
		S_AXI_BREADY = 1'b1;
		@(negedge S_AXI_ACLK);
		S_AXI_BREADY = 1'b0;
		// response gone and no second one behind it
		repeat (3) begin
			check_eq("S_AXI_BVALID", S_AXI_BVALID, 0);
			if (S_AXI_AWREADY)
				accepts++;
			@(negedge S_AXI_ACLK);
		end
		check_eq("accepted write count", accepts, 1);
	endtask

	// next falling edge inside a frame-start cycle
	task automatic wait_tick();
		int cycles;
		cycles = 0;
		@(negedge S_AXI_ACLK);
		while (!flt_tick) begin
			@(negedge S_AXI_ACLK);
			cycles++;
			if (cycles > WAIT_LIMIT)
				abort_run("timeout waiting for flt_tick");
		end
	endtask

	// frame strobe repeats every TM clocks
	task automatic check_tick_period();
		int cycles;
		wait_tick();
		cycles = 0;
		do begin
			@(negedge S_AXI_ACLK);
			cycles++;
			if (cycles > WAIT_LIMIT)
				abort_run("timeout waiting for the next flt_tick");
		end while (!flt_tick);
		check_eq("flt_tick period", cycles, fir_pkg::TM);
	endtask

	task automatic write_coef(input int k, input logic [fir_pkg::COEF_W-1:0] c);
		coef_m[k] = int'($signed(c));
		// sign only in bit 31 and its inverse in the unused bits
		axi_write(coef_addr(k / fir_pkg::TM, k % fir_pkg::TM),
			{c[fir_pkg::COEF_W-1],
			{(fir_pkg::AXI_DATA_W - fir_pkg::COEF_W){~c[fir_pkg::COEF_W-1]}},
			c[fir_pkg::COEF_W-2:0]});
	endtask

	// zero the whole history, model restarts clean
	task automatic flush_history();
		repeat (fir_pkg::NTAPS) begin
			wait_tick();
			flt_in = '0;
		end
		for (int k = 0; k < fir_pkg::NTAPS; k++)
			hist_m[k] = 0;
		exp_q.delete();
	endtask

	// one sample per frame, output checked mid-frame two ticks later
	task automatic feed_sample(input logic signed [fir_pkg::DATA_W-1:0] x);
		logic signed [fir_pkg::DATA_W-1:0] want;
		wait_tick();
		flt_in = x;
		for (int k = fir_pkg::NTAPS - 1; k > 0; k--)
			hist_m[k] = hist_m[k-1];
		hist_m[0] = int'(x);
		exp_q.push_back(expected_output());
		repeat (fir_pkg::TM / 2) @(negedge S_AXI_ACLK);
		if (exp_q.size() == 3) begin
			want = exp_q.pop_front();
			check_eq("flt_out", flt_out, want);
		end
	endtask

	task automatic test_reset_values();
		logic [31:0] d;
		axi_read(reg_addr(fir_pkg::REG_NAME), d);
		check_eq("REG_NAME", d, fir_pkg::PROG_NAME);
		axi_read(reg_addr(fir_pkg::REG_VER), d);
		check_eq("REG_VER", d, fir_pkg::PROG_VER);
		axi_read(reg_addr(fir_pkg::REG_NTAPS), d);
		check_eq("REG_NTAPS", d, fir_pkg::NTAPS);
		axi_read(reg_addr(fir_pkg::REG_TM), d);
		check_eq("REG_TM", d, fir_pkg::TM);
		axi_read(reg_addr(fir_pkg::REG_DSP_NR), d);
		check_eq("REG_DSP_NR", d, fir_pkg::DSP_NR);
		axi_read(reg_addr(fir_pkg::REG_COEF_MAG), d);
		check_eq("REG_COEF_MAG", d, fir_pkg::COEF_MAG);
		axi_read(reg_addr(fir_pkg::REG_COEF_BASE), d);
		check_eq("REG_COEF_BASE", d, fir_pkg::FIR_COEFS_BASE);
		// word 2 has no register behind it
		axi_read(16'h0008, d);
		check_eq("unmapped read", d, 0);
		axi_read(coef_addr(1, 3), d);
		check_eq("coefficient read", d, 0);
		axi_write(reg_addr(fir_pkg::REG_SWITCHES), 32'(1) << fir_pkg::SW_FIR_EN);
		flt_in = fir_pkg::DATA_W'($urandom);
		repeat (2) @(negedge S_AXI_ACLK);
		check_eq("flt_out", flt_out, 0);
		check_tick_period();
	endtask

	task automatic test_switches();
		logic [31:0] w;
		logic [31:0] d;
		w = $urandom;
		axi_write(reg_addr(fir_pkg::REG_SWITCHES), w);
		axi_read(reg_addr(fir_pkg::REG_SWITCHES), d);
		check_eq("REG_SWITCHES", d, w);
		check_eq("leds", leds, w[fir_pkg::LED_W-1:0]);
		w = $urandom;
		write_stalled_response(reg_addr(fir_pkg::REG_SWITCHES), w, 5);
		axi_read(reg_addr(fir_pkg::REG_SWITCHES), d);
		check_eq("REG_SWITCHES", d, w);
		check_eq("leds", leds, w[fir_pkg::LED_W-1:0]);
	endtask

	task automatic test_bypass();
		axi_write(reg_addr(fir_pkg::REG_SWITCHES), 32'h0);
		repeat (6) begin
			wait_tick();
			repeat (2) @(negedge S_AXI_ACLK);
			flt_in = fir_pkg::DATA_W'($urandom);
			repeat (2) @(negedge S_AXI_ACLK);
			check_eq("flt_out", flt_out, flt_in);
		end
	endtask

	task automatic test_impulse();
		axi_write(reg_addr(fir_pkg::REG_SWITCHES), 32'(1) << fir_pkg::SW_FIR_EN);
		for (int k = 0; k < fir_pkg::NTAPS; k++)
			write_coef(k, fir_pkg::COEF_W'($urandom));
		flush_history();
		feed_sample(fir_pkg::DATA_W'($urandom_range(1, 8191)));
		// two extra frames drain the last outputs
		repeat (fir_pkg::NTAPS + 1)
			feed_sample('0);
	endtask

	task automatic test_stream();
		for (int round = 0; round < 2; round++) begin
			// second round runs with one coefficient changed
			if (round == 1)
				write_coef($urandom_range(0, fir_pkg::NTAPS - 1), fir_pkg::COEF_W'($urandom));
			flush_history();
			repeat (40)
				feed_sample(fir_pkg::DATA_W'(int'($urandom_range(0, 4095)) - 2048));
			// two zero frames bring out the last two outputs
			repeat (2)
				feed_sample('0);
		end
	endtask

	initial begin
		void'($urandom(26723));
		S_AXI_ARESETN = 1'b0;
		S_AXI_AWADDR = '0;
		S_AXI_AWVALID = 1'b0;
		S_AXI_WDATA = '0;
		S_AXI_WSTRB = '0;
		S_AXI_WVALID = 1'b0;
		S_AXI_BREADY = 1'b0;
		S_AXI_ARADDR = '0;
		S_AXI_ARVALID = 1'b0;
		S_AXI_RREADY = 1'b0;
		flt_in = '0;
		// reset clears coefficients and histories
		for (int k = 0; k < fir_pkg::NTAPS; k++) begin
			coef_m[k] = 0;
			hist_m[k] = 0;
		end
		repeat (8) @(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;
		test_reset_values();
		test_switches();
		test_bypass();
		test_impulse();
		test_stream();
		$display("=== PASS ===");
		$finish;
	end

endmodule

// File: files.f
common/fir_pkg.sv
common/coef_wr_if.sv
rtl/axi_lite_regs.sv
fir/fir_tap.sv
fir/fir_engine.sv
rtl/fir_axi_top.sv
tests/fir_axi_tb.sv

// File: Bender.yml
package:
  name: fir_axi

sources:
  - common/fir_pkg.sv
  - common/coef_wr_if.sv
  - rtl/axi_lite_regs.sv
  - fir/fir_tap.sv
  - fir/fir_engine.sv
  - rtl/fir_axi_top.sv
  - target: test
    files:
      - tests/fir_axi_tb.sv
